// ==== all.f ====
verilog/sdio_pkg.sv
verilog/sdio_crc7.sv
verilog/sdio_cmd_phy.sv
verilog/sdio_cmd_handler.sv
verilog/sdio_reg_arbiter.sv
verilog/sdio_reg_file.sv
verilog/sdio_device_core.sv
testbench/tb_sdio_device.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --assert --timing --timescale 1ns/100ps -Wno-fatal
TOP       := tb_sdio_device
FILELIST  := all.f
OBJ_DIR   := obj_dir
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/tb_sdio_device.sv ====
`timescale 1ns/100ps

module tb_sdio_device;

  // About 200 cycles per host command, including the long CRC error wait
  localparam int CMD_COUNT = 13;
  localparam int RSP_WAIT  = 20;
  localparam int GNT_WAIT  = 10;

  logic                            sdio_clk;
  logic                            rst;
  logic                            sdio_cmd_in;
  logic                            sdio_cmd_out;
  logic                            sdio_cmd_dir;
  logic                            func_req;
  logic                            func_we;
  logic [sdio_pkg::REG_ADDR_W-1:0] func_addr;
  logic [7:0]                      func_wdata;
  logic                            func_gnt;
  logic                            func_rvalid;
  logic [7:0]                      func_rdata;

  integer     seed;
  string      test_name;
  int         err_cnt;
  int         err_start;
  int         test_cnt;
  int         test_fail_cnt;
  logic [7:0] model [16];

  sdio_device_core i_dut (
    .sdio_clk     (sdio_clk),
    .rst          (rst),
    .sdio_cmd_in  (sdio_cmd_in),
    .sdio_cmd_out (sdio_cmd_out),
    .sdio_cmd_dir (sdio_cmd_dir),
    .func_req     (func_req),
    .func_we      (func_we),
    .func_addr    (func_addr),
    .func_wdata   (func_wdata),
    .func_gnt     (func_gnt),
    .func_rvalid  (func_rvalid),
    .func_rdata   (func_rdata)
  );

  always #20 sdio_clk = ~sdio_clk;

  // x^7 + x^3 + 1, MSB first
  function automatic logic [6:0] crc7_calc(input logic [39:0] bits);
    logic [6:0] c;
    logic       fb;
    c = 7'h00;
    for (int i = 39; i >= 0; i--) begin
      fb = c[6] ^ bits[i];
      c  = {c[5:0], 1'b0};
      if (fb) begin
        c = c ^ 7'h09;
      end
    end
    return c;
  endfunction

  function automatic logic [31:0] cmd52_arg(input logic we, input logic [16:0] addr,
                                            input logic [7:0] data);
    logic [31:0] arg;
    arg        = 32'h0;
    arg[31]    = we;
    arg[25:9]  = addr;
    arg[7:0]   = data;
    return arg;
  endfunction

  task automatic expect_eq(input string what, input logic [47:0] exp, input logic [47:0] act);
    assert (act === exp) else begin
      $display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    err_start = err_cnt;
    test_cnt++;
  endtask

  task automatic end_test();
    if (err_cnt == err_start) begin
      $display("test %s: passed", test_name);
    end else begin
      $display("test %s: failed with %0d errors", test_name, err_cnt - err_start);
      test_fail_cnt++;
    end
  endtask

  // Host to device frame, direction bit 1
  task automatic send_cmd(input logic [5:0] index, input logic [31:0] arg,
                          input logic corrupt);
    logic [39:0] head;
    logic [6:0]  crc;
    logic [47:0] frame;
    head = {1'b0, 1'b1, index, arg};
    crc  = crc7_calc(head);
    if (corrupt) begin
      crc = crc ^ 7'h01;
    end
    frame = {head, crc, 1'b1};
    for (int i = sdio_pkg::FRAME_BITS - 1; i >= 0; i--) begin
      @(posedge sdio_clk);
      sdio_cmd_in <= frame[i];
    end
  endtask

  task automatic get_rsp(output logic [47:0] rsp, output logic ok);
    int wait_cnt;
    int high_cnt;
    rsp      = '0;
    ok       = 1'b0;
    wait_cnt = 0;
    @(negedge sdio_clk);
    while (!sdio_cmd_dir && wait_cnt < RSP_WAIT) begin
      @(negedge sdio_clk);
      wait_cnt++;
    end
    assert (sdio_cmd_dir) else begin
      $display("%s: the device sent no response", test_name);
      err_cnt++;
    end
    if (!sdio_cmd_dir) begin
      return;
    end
    high_cnt = 0;
    for (int i = sdio_pkg::FRAME_BITS - 1; i >= 0; i--) begin
      rsp[i] = sdio_cmd_out;
      if (sdio_cmd_dir) begin
        high_cnt++;
      end
      @(negedge sdio_clk);
    end
    // One cycle past the end bit the line must be released
    expect_eq("dir cycles", 48, high_cnt + int'(sdio_cmd_dir));
    expect_eq("start bit", 0, rsp[47]);
    expect_eq("direction bit", 0, rsp[46]);
    expect_eq("response crc", crc7_calc(rsp[47:8]), rsp[7:1]);
    expect_eq("end bit", 1, rsp[0]);
    ok = 1'b1;
  endtask

  // R5 payload is index, 16 zero bits, flags, data
  task automatic host_cmd(input logic [5:0] index, input logic [31:0] arg,
                          input logic [7:0] exp_flags, input logic [7:0] exp_data);
    logic [47:0] rsp;
    logic        ok;
    send_cmd(index, arg, 1'b0);
    get_rsp(rsp, ok);
    if (ok) begin
      expect_eq("echoed index", index, rsp[45:40]);
      expect_eq("stuff bits", 0, rsp[39:24]);
      expect_eq("flags", exp_flags, rsp[23:16]);
      expect_eq("data", exp_data, rsp[15:8]);
    end
  endtask

  task automatic host_cmd52(input logic we, input logic [16:0] addr, input logic [7:0] wdata,
                            input logic [7:0] exp_flags, input logic [7:0] exp_data);
    host_cmd(6'd52, cmd52_arg(we, addr, wdata), exp_flags, exp_data);
    if (we && addr < 17'd16) begin
      model[addr[3:0]] = wdata;
    end
  endtask

  task automatic func_access(input logic we, input logic [3:0] addr, input logic [7:0] wdata,
                             output logic [7:0] rdata, output int waited);
    int wait_cnt;
    rdata  = 8'h00;
    waited = 0;
    @(posedge sdio_clk);
    func_req   <= 1'b1;
    func_we    <= we;
    func_addr  <= addr;
    func_wdata <= wdata;
    @(negedge sdio_clk);
    while (!func_gnt && waited < GNT_WAIT) begin
      waited++;
      @(negedge sdio_clk);
    end
    assert (func_gnt) else begin
      $display("%s: function port request was never granted", test_name);
      err_cnt++;
    end
    @(posedge sdio_clk);
    func_req <= 1'b0;
    func_we  <= 1'b0;
    if (!we && waited < GNT_WAIT) begin
      wait_cnt = 0;
      @(negedge sdio_clk);
      while (!func_rvalid && wait_cnt < GNT_WAIT) begin
        wait_cnt++;
        @(negedge sdio_clk);
      end
      assert (func_rvalid) else begin
        $display("%s: function port read data never arrived", test_name);
        err_cnt++;
      end
      rdata = func_rdata;
    end
  endtask

  task automatic test_write_read();
    logic [3:0] addr;
    logic [7:0] data;
    begin_test("write_read");
    addr = 4'($random(seed));
    data = 8'($random(seed));
    host_cmd52(1'b1, {13'd0, addr}, data, 8'h00, data);
    host_cmd52(1'b0, {13'd0, addr}, 8'h00, 8'h00, data);
    end_test();
  endtask

  task automatic test_out_of_range();
    logic [7:0] data;
    begin_test("out_of_range");
    data = 8'($random(seed));
    // OUT_OF_RANGE is flag bit 0
    host_cmd52(1'b1, 17'd20, data, 8'h01, 8'h00);
    host_cmd52(1'b0, 17'd4, 8'h00, 8'h00, model[4]);
    end_test();
  endtask

  task automatic test_illegal_cmd();
    begin_test("illegal_cmd");
    // ILLEGAL_COMMAND is flag bit 6, the write flag and data byte must not come back
    host_cmd(6'd5, 32'h80ff_805a, 8'h40, 8'h00);
    end_test();
  endtask

  task automatic test_crc_error();
    int high_cnt;
    begin_test("crc_error");
    high_cnt = 0;
    send_cmd(6'd52, cmd52_arg(1'b0, 17'd3, 8'h00), 1'b1);
    repeat (60) begin
      @(negedge sdio_clk);
      if (sdio_cmd_dir) begin
        high_cnt++;
      end
    end
    expect_eq("dir cycles after bad crc", 0, high_cnt);
    // COM_CRC_ERROR is flag bit 7, reported once
    host_cmd52(1'b0, 17'd3, 8'h00, 8'h80, model[3]);
    host_cmd52(1'b0, 17'd3, 8'h00, 8'h00, model[3]);
    end_test();
  endtask

  task automatic test_shared_regs();
    logic [7:0] val;
    logic [7:0] rd;
    int         waited;
    begin_test("shared_regs");
    val = 8'($random(seed));
    func_access(1'b1, 4'd9, val, rd, waited);
    model[9] = val;
    host_cmd52(1'b0, 17'd9, 8'h00, 8'h00, val);
    val = 8'($random(seed));
    host_cmd52(1'b1, 17'd12, val, 8'h00, val);
    func_access(1'b0, 4'd12, 8'h00, rd, waited);
    expect_eq("function read", val, rd);
    // Function read raised in the cycle the handler holds the bus
    val = 8'($random(seed));
    fork
      host_cmd52(1'b1, 17'd14, val, 8'h00, val);
      begin
        repeat (sdio_pkg::FRAME_BITS + 1) @(posedge sdio_clk);
        func_access(1'b0, 4'd14, 8'h00, rd, waited);
      end
    join
    assert (waited > 0) else begin
      $display("%s: function port was granted while the handler held the bus", test_name);
      err_cnt++;
    end
    expect_eq("held function read", val, rd);
    end_test();
  endtask

  task automatic test_rsp_format();
    begin_test("rsp_format");
    host_cmd52(1'b1, 17'd15, 8'hff, 8'h00, 8'hff);
    host_cmd52(1'b0, 17'd15, 8'h00, 8'h00, 8'hff);
    end_test();
  endtask

  initial begin
    sdio_clk      = 1'b0;
    rst           = 1'b1;
    sdio_cmd_in   = 1'b1;
    func_req      = 1'b0;
    func_we       = 1'b0;
    func_addr     = '0;
    func_wdata    = 8'h00;
    seed          = 32'h61ce;
    err_cnt       = 0;
    test_cnt      = 0;
    test_fail_cnt = 0;
    for (int i = 0; i < 16; i++) begin
      model[i] = 8'h00;
    end
    repeat (8) @(posedge sdio_clk);
    rst <= 1'b0;
    repeat (2) @(posedge sdio_clk);
    test_write_read();
    test_out_of_range();
    test_illegal_cmd();
    test_crc_error();
    test_shared_regs();
    test_rsp_format();
    $display("summary: %0d tests, %0d failed, %0d errors", test_cnt, test_fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    repeat (8 + CMD_COUNT * 200) @(posedge sdio_clk);
    $display("watchdog: the tests did not finish in time");
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== verilog/sdio_device_core.sv ====
`timescale 1ns/100ps

module sdio_device_core (
  input  logic                            sdio_clk,
  input  logic                            rst,
  input  logic                            sdio_cmd_in,
  output logic                            sdio_cmd_out,
  output logic                            sdio_cmd_dir,
  input  logic                            func_req,
  input  logic                            func_we,
  input  logic [sdio_pkg::REG_ADDR_W-1:0] func_addr,
  input  logic [7:0]                      func_wdata,
  output logic                            func_gnt,
  output logic                            func_rvalid,
  output logic [7:0]                      func_rdata
);

  logic                            cmd_stb;
  logic                            crc_err_stb;
  logic [5:0]                      cmd_index;
  logic [31:0]                     cmd_arg;
  logic                            rsp_stb;
  logic [sdio_pkg::RSP_BITS-1:0]   rsp_bits;
  logic                            cmd_req;
  logic                            cmd_we;
  logic [sdio_pkg::REG_ADDR_W-1:0] cmd_addr;
  logic [7:0]                      cmd_wdata;
  logic                            cmd_gnt;
  logic                            cmd_rvalid;
  logic                            reg_en;
  logic                            reg_we;
  logic [sdio_pkg::REG_ADDR_W-1:0] reg_addr;
  logic [7:0]                      reg_wdata;
  logic [7:0]                      reg_rdata;

  sdio_cmd_phy i_phy (
    .sdio_clk     (sdio_clk),
    .rst          (rst),
    .sdio_cmd_in  (sdio_cmd_in),
    .rsp_stb      (rsp_stb),
    .rsp_bits     (rsp_bits),
    .sdio_cmd_out (sdio_cmd_out),
    .sdio_cmd_dir (sdio_cmd_dir),
    .cmd_stb      (cmd_stb),
    .crc_err_stb  (crc_err_stb),
    .cmd_index    (cmd_index),
    .cmd_arg      (cmd_arg)
  );

  sdio_cmd_handler i_handler (
    .sdio_clk    (sdio_clk),
    .rst         (rst),
    .cmd_stb     (cmd_stb),
    .crc_err_stb (crc_err_stb),
    .cmd_index   (cmd_index),
    .cmd_arg     (cmd_arg),
    .cmd_gnt     (cmd_gnt),
    .cmd_rvalid  (cmd_rvalid),
    .rdata       (func_rdata),
    .cmd_req     (cmd_req),
    .cmd_we      (cmd_we),
    .cmd_addr    (cmd_addr),
    .cmd_wdata   (cmd_wdata),
    .rsp_stb     (rsp_stb),
    .rsp_bits    (rsp_bits)
  );

  // Read data is shared, the rvalids tell the peers apart
  sdio_reg_arbiter i_arbiter (
    .sdio_clk    (sdio_clk),
    .rst         (rst),
    .cmd_req     (cmd_req),
    .cmd_we      (cmd_we),
    .cmd_addr    (cmd_addr),
    .cmd_wdata   (cmd_wdata),
    .func_req    (func_req),
    .func_we     (func_we),
    .func_addr   (func_addr),
    .func_wdata  (func_wdata),
    .reg_rdata   (reg_rdata),
    .cmd_gnt     (cmd_gnt),
    .func_gnt    (func_gnt),
    .cmd_rvalid  (cmd_rvalid),
    .func_rvalid (func_rvalid),
    .rdata       (func_rdata),
    .reg_en      (reg_en),
    .reg_we      (reg_we),
    .reg_addr    (reg_addr),
    .reg_wdata   (reg_wdata)
  );

  sdio_reg_file i_reg_file (
    .sdio_clk  (sdio_clk),
    .rst       (rst),
    .reg_en    (reg_en),
    .reg_we    (reg_we),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata)
  );

endmodule

// ==== verilog/sdio_reg_file.sv ====
`timescale 1ns/100ps

module sdio_reg_file (
  input  logic                            sdio_clk,
  input  logic                            rst,
  input  logic                            reg_en,
  input  logic                            reg_we,
  input  logic [sdio_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [7:0]                      reg_wdata,
  output logic [7:0]                      reg_rdata
);

  logic [7:0] regs [sdio_pkg::REG_COUNT];

  // Function registers come up cleared
  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      for (int i = 0; i < sdio_pkg::REG_COUNT; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (reg_en && reg_we) begin
      regs[reg_addr] <= reg_wdata;
    end
  end

  // One cycle read latency
  always_ff @(posedge sdio_clk) begin
    if (reg_en && !reg_we) begin
      reg_rdata <= regs[reg_addr];
    end
  end

endmodule

// ==== verilog/sdio_reg_arbiter.sv ====
`timescale 1ns/100ps

module sdio_reg_arbiter (
  input  logic                            sdio_clk,
  input  logic                            rst,
  input  logic                            cmd_req,
  input  logic                            cmd_we,
  input  logic [sdio_pkg::REG_ADDR_W-1:0] cmd_addr,
  input  logic [7:0]                      cmd_wdata,
  input  logic                            func_req,
  input  logic                            func_we,
  input  logic [sdio_pkg::REG_ADDR_W-1:0] func_addr,
  input  logic [7:0]                      func_wdata,
  input  logic [7:0]                      reg_rdata,
  output logic                            cmd_gnt,
  output logic                            func_gnt,
  output logic                            cmd_rvalid,
  output logic                            func_rvalid,
  output logic [7:0]                      rdata,
  output logic                            reg_en,
  output logic                            reg_we,
  output logic [sdio_pkg::REG_ADDR_W-1:0] reg_addr,
  output logic [7:0]                      reg_wdata
);

  // Host commands always win
  assign cmd_gnt  = cmd_req;
  assign func_gnt = func_req && !cmd_req;

  assign reg_en    = cmd_gnt || func_gnt;
  assign reg_we    = cmd_gnt ? cmd_we    : func_we;
  assign reg_addr  = cmd_gnt ? cmd_addr  : func_addr;
  assign reg_wdata = cmd_gnt ? cmd_wdata : func_wdata;
  assign rdata     = reg_rdata;

  // Read owner, lines up with the registered read data
  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      cmd_rvalid  <= 1'b0;
      func_rvalid <= 1'b0;
    end else begin
      cmd_rvalid  <= cmd_gnt && !cmd_we;
      func_rvalid <= func_gnt && !func_we;
    end
  end

  // A waiting function request stays up until it is granted
  a_func_hold : assert property (@(posedge sdio_clk) disable iff (rst)
    func_req && !func_gnt |=> func_req);

endmodule

// ==== verilog/sdio_cmd_handler.sv ====
`timescale 1ns/100ps

module sdio_cmd_handler (
  input  logic                            sdio_clk,
  input  logic                            rst,
  input  logic                            cmd_stb,
  input  logic                            crc_err_stb,
  input  logic [5:0]                      cmd_index,
  input  logic [31:0]                     cmd_arg,
  input  logic                            cmd_gnt,
  input  logic                            cmd_rvalid,
  input  logic [7:0]                      rdata,
  output logic                            cmd_req,
  output logic                            cmd_we,
  output logic [sdio_pkg::REG_ADDR_W-1:0] cmd_addr,
  output logic [7:0]                      cmd_wdata,
  output logic                            rsp_stb,
  output logic [sdio_pkg::RSP_BITS-1:0]   rsp_bits
);

  sdio_pkg::handler_op_e state;
  logic [sdio_pkg::ARG_ADDR_HI-sdio_pkg::ARG_ADDR_LO:0] req_addr;
  logic [5:0]  idx_q;
  logic [31:0] arg_q;
  logic [7:0]  rd_q;
  logic        illegal_q;
  logic        oor_q;
  logic        crc_flag;
  logic [7:0]  flags;
  logic [7:0]  rsp_data;

  assign req_addr  = cmd_arg[sdio_pkg::ARG_ADDR_HI:sdio_pkg::ARG_ADDR_LO];
  assign cmd_we    = arg_q[sdio_pkg::ARG_RW];
  assign cmd_addr  = arg_q[sdio_pkg::ARG_ADDR_LO +: sdio_pkg::REG_ADDR_W];
  assign cmd_wdata = arg_q[7:0];

  always_comb begin
    flags = 8'h00;
    flags[sdio_pkg::FLAG_COM_CRC]      = crc_flag;
    flags[sdio_pkg::FLAG_ILLEGAL]      = illegal_q;
    flags[sdio_pkg::FLAG_OUT_OF_RANGE] = oor_q;
  end

  // Rejected commands carry no data
  assign rsp_data = (illegal_q || oor_q) ? 8'h00 : (cmd_we ? arg_q[7:0] : rd_q);
  assign rsp_bits = {idx_q, 16'h0000, flags, rsp_data};

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state     <= sdio_pkg::H_IDLE;
      cmd_req   <= 1'b0;
      rsp_stb   <= 1'b0;
      illegal_q <= 1'b0;
      oor_q     <= 1'b0;
      crc_flag  <= 1'b0;
    end else begin
      // Sticky until the next response has gone out
      if (crc_err_stb) begin
        crc_flag <= 1'b1;
      end else if (state == sdio_pkg::H_RESPOND) begin
        crc_flag <= 1'b0;
      end
      case (state)
        sdio_pkg::H_IDLE: begin
          if (cmd_stb) begin
            if (cmd_index != sdio_pkg::CMD_IO_RW_DIRECT) begin
              illegal_q <= 1'b1;
              oor_q     <= 1'b0;
              rsp_stb   <= 1'b1;
              state     <= sdio_pkg::H_RESPOND;
            end else if (req_addr >= sdio_pkg::REG_COUNT) begin
              illegal_q <= 1'b0;
              oor_q     <= 1'b1;
              rsp_stb   <= 1'b1;
              state     <= sdio_pkg::H_RESPOND;
            end else begin
              illegal_q <= 1'b0;
              oor_q     <= 1'b0;
              cmd_req   <= 1'b1;
              state     <= sdio_pkg::H_ACCESS;
            end
          end
        end
        sdio_pkg::H_ACCESS: begin
          if (cmd_gnt) begin
            cmd_req <= 1'b0;
            if (cmd_we) begin
              rsp_stb <= 1'b1;
              state   <= sdio_pkg::H_RESPOND;
            end else begin
              state <= sdio_pkg::H_READBACK;
            end
          end
        end
        sdio_pkg::H_READBACK: begin
          if (cmd_rvalid) begin
            rsp_stb <= 1'b1;
            state   <= sdio_pkg::H_RESPOND;
          end
        end
        default: begin
          rsp_stb <= 1'b0;
          state   <= sdio_pkg::H_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge sdio_clk) begin
    if ((state == sdio_pkg::H_IDLE) && cmd_stb) begin
      idx_q <= cmd_index;
      arg_q <= cmd_arg;
    end
    if ((state == sdio_pkg::H_READBACK) && cmd_rvalid) begin
      rd_q <= rdata;
    end
  end

  a_rsp_in_respond : assert property (@(posedge sdio_clk) disable iff (rst)
    rsp_stb |-> state == sdio_pkg::H_RESPOND);

endmodule

// ==== verilog/sdio_cmd_phy.sv ====
`timescale 1ns/100ps

module sdio_cmd_phy (
  input  logic                          sdio_clk,
  input  logic                          rst,
  input  logic                          sdio_cmd_in,
  input  logic                          rsp_stb,
  input  logic [sdio_pkg::RSP_BITS-1:0] rsp_bits,
  output logic                          sdio_cmd_out,
  output logic                          sdio_cmd_dir,
  output logic                          cmd_stb,
  output logic                          crc_err_stb,
  output logic [5:0]                    cmd_index,
  output logic [31:0]                   cmd_arg
);

  sdio_pkg::phy_state_e state;
  logic [5:0]                    bit_cnt;
  logic [6:0]                    rx_crc;
  logic [sdio_pkg::RSP_BITS-1:0] tx_shift;
  logic [6:0]                    crc;
  logic                          crc_msb;
  logic                          crc_clear;
  logic                          crc_hold;
  logic                          crc_shift;
  logic                          crc_in;
  logic                          rx_acc;
  logic                          tx_acc;

  // Receive covers bits 1..39, transmit covers each payload bit as it is loaded
  assign rx_acc = (state == sdio_pkg::READ_COMMAND) && (bit_cnt < sdio_pkg::BIT_CRC_START);
  assign tx_acc = (state == sdio_pkg::RESPONSE_DIR_BIT) ||
                  ((state == sdio_pkg::RESPONSE) && (bit_cnt < sdio_pkg::RSP_BITS));

  assign crc_clear = (state == sdio_pkg::IDLE) || (state == sdio_pkg::WAIT_RESPONSE);
  assign crc_hold  = !(rx_acc || tx_acc);
  assign crc_shift = ((state == sdio_pkg::RESPONSE) && (bit_cnt == sdio_pkg::RSP_BITS)) ||
                     ((state == sdio_pkg::RESPONSE_CRC) && (bit_cnt < sdio_pkg::CRC_BITS));
  assign crc_in    = (state == sdio_pkg::READ_COMMAND) ? sdio_cmd_in
                                                       : tx_shift[sdio_pkg::RSP_BITS-1];

  sdio_crc7 i_crc7 (
    .sdio_clk  (sdio_clk),
    .clear     (crc_clear),
    .hold      (crc_hold),
    .shift_out (crc_shift),
    .bit_in    (crc_in),
    .crc       (crc),
    .crc_msb   (crc_msb)
  );

  always_ff @(posedge sdio_clk) begin
    if (rst) begin
      state        <= sdio_pkg::IDLE;
      bit_cnt      <= '0;
      cmd_stb      <= 1'b0;
      crc_err_stb  <= 1'b0;
      sdio_cmd_out <= 1'b1;
      sdio_cmd_dir <= 1'b0;
    end else begin
      cmd_stb     <= 1'b0;
      crc_err_stb <= 1'b0;
      case (state)
        sdio_pkg::IDLE: begin
          sdio_cmd_out <= 1'b1;
          sdio_cmd_dir <= 1'b0;
          // Start bit sampled here counts as bit 0
          if (!sdio_cmd_in) begin
            bit_cnt <= 6'd1;
            state   <= sdio_pkg::READ_COMMAND;
          end
        end
        sdio_pkg::READ_COMMAND: begin
          if (bit_cnt == sdio_pkg::FRAME_BITS - 1) begin
            cmd_stb     <= (rx_crc == crc);
            crc_err_stb <= (rx_crc != crc);
            bit_cnt     <= '0;
            state       <= (rx_crc == crc) ? sdio_pkg::WAIT_RESPONSE : sdio_pkg::IDLE;
          end else begin
            bit_cnt <= bit_cnt + 6'd1;
          end
        end
        sdio_pkg::WAIT_RESPONSE: begin
          sdio_cmd_out <= 1'b1;
          sdio_cmd_dir <= 1'b0;
          if (rsp_stb) begin
            sdio_cmd_out <= 1'b0;
            sdio_cmd_dir <= 1'b1;
            state        <= sdio_pkg::RESPONSE_START;
          end
        end
        sdio_pkg::RESPONSE_START: begin
          // Direction bit, device to host
          sdio_cmd_out <= 1'b0;
          state        <= sdio_pkg::RESPONSE_DIR_BIT;
        end
        sdio_pkg::RESPONSE_DIR_BIT: begin
          sdio_cmd_out <= tx_shift[sdio_pkg::RSP_BITS-1];
          bit_cnt      <= 6'd1;
          state        <= sdio_pkg::RESPONSE;
        end
        sdio_pkg::RESPONSE: begin
          if (bit_cnt < sdio_pkg::RSP_BITS) begin
            sdio_cmd_out <= tx_shift[sdio_pkg::RSP_BITS-1];
            bit_cnt      <= bit_cnt + 6'd1;
          end else begin
            sdio_cmd_out <= crc_msb;
            bit_cnt      <= 6'd1;
            state        <= sdio_pkg::RESPONSE_CRC;
          end
        end
        sdio_pkg::RESPONSE_CRC: begin
          if (bit_cnt < sdio_pkg::CRC_BITS) begin
            sdio_cmd_out <= crc_msb;
            bit_cnt      <= bit_cnt + 6'd1;
          end else begin
            // End bit
            sdio_cmd_out <= 1'b1;
            bit_cnt      <= '0;
            state        <= sdio_pkg::RESPONSE_FINISHED;
          end
        end
        sdio_pkg::RESPONSE_FINISHED: begin
          sdio_cmd_out <= 1'b1;
          sdio_cmd_dir <= 1'b0;
          state        <= sdio_pkg::IDLE;
        end
        default: begin
          sdio_cmd_dir <= 1'b0;
          state        <= sdio_pkg::IDLE;
        end
      endcase
    end
  end

  // Field capture and response shifter
  always_ff @(posedge sdio_clk) begin
    if (state == sdio_pkg::READ_COMMAND) begin
      if (bit_cnt >= sdio_pkg::BIT_CMD_START && bit_cnt <= sdio_pkg::BIT_CMD_END) begin
        cmd_index <= {cmd_index[4:0], sdio_cmd_in};
      end
      if (bit_cnt >= sdio_pkg::BIT_ARG_START && bit_cnt <= sdio_pkg::BIT_ARG_END) begin
        cmd_arg <= {cmd_arg[30:0], sdio_cmd_in};
      end
      if (bit_cnt >= sdio_pkg::BIT_CRC_START && bit_cnt <= sdio_pkg::BIT_CRC_END) begin
        rx_crc <= {rx_crc[5:0], sdio_cmd_in};
      end
    end
    if ((state == sdio_pkg::WAIT_RESPONSE) && rsp_stb) begin
      tx_shift <= rsp_bits;
    end else if (tx_acc) begin
      tx_shift <= {tx_shift[sdio_pkg::RSP_BITS-2:0], 1'b0};
    end
  end

  // Line is only driven while a response is in flight
  a_dir_idle : assert property (@(posedge sdio_clk) disable iff (rst)
    !(sdio_cmd_dir && (state == sdio_pkg::IDLE || state == sdio_pkg::READ_COMMAND)));

endmodule

// ==== verilog/sdio_crc7.sv ====
`timescale 1ns/100ps

module sdio_crc7 (
  input  logic       sdio_clk,
  input  logic       clear,
  input  logic       hold,
  input  logic       shift_out,
  input  logic       bit_in,
  output logic [6:0] crc,
  output logic       crc_msb
);

  logic fb;

  // x^7 + x^3 + 1
  assign fb      = crc[6] ^ bit_in;
  assign crc_msb = crc[6];

  always_ff @(posedge sdio_clk) begin
    if (clear) begin
      crc <= 7'h00;
    end else if (shift_out) begin
      // Remainder leaves MSB first
      crc <= {crc[5:0], 1'b0};
    end else if (!hold) begin
      crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
    end
  end

endmodule

// ==== verilog/sdio_pkg.sv ====
package sdio_pkg;

  // Command frame layout, bit 0 is the start bit
  localparam int FRAME_BITS    = 48;
  localparam int BIT_DIR       = 1;
  localparam int BIT_CMD_START = 2;
  localparam int BIT_CMD_END   = 7;
  localparam int BIT_ARG_START = 8;
  localparam int BIT_ARG_END   = 39;
  localparam int BIT_CRC_START = 40;
  localparam int BIT_CRC_END   = 46;

  // Response payload between direction bit and CRC
  localparam int RSP_BITS = 38;
  localparam int CRC_BITS = 7;

  // Function register file
  localparam int REG_ADDR_W = 4;
  localparam int REG_COUNT  = 16;

  // CMD52 argument fields
  localparam int ARG_RW      = 31;
  localparam int ARG_ADDR_LO = 9;
  localparam int ARG_ADDR_HI = 25;

  // R5 flags byte
  localparam int FLAG_COM_CRC      = 7;
  localparam int FLAG_ILLEGAL      = 6;
  localparam int FLAG_OUT_OF_RANGE = 0;

  localparam int CMD_IO_RW_DIRECT = 52;

  typedef enum logic [2:0] {
    IDLE,
    READ_COMMAND,
    WAIT_RESPONSE,
    RESPONSE_START,
    RESPONSE_DIR_BIT,
    RESPONSE,
    RESPONSE_CRC,
    RESPONSE_FINISHED
  } phy_state_e;

  typedef enum logic [1:0] {
    H_IDLE,
    H_ACCESS,
    H_READBACK,
    H_RESPOND
  } handler_op_e;

endpackage
